//--- verilog/wb_pkg.sv
// Shared definitions for the writeback core: default widths, operation codes,
// the APB register map, CMD field positions and the unit result record.
// Modules refer to these by scoped name.
package wb_pkg;

	localparam int XLEN_DEF = 64;
	localparam int NREG = 32;
	localparam int RP_DEF = 4;

	// record fields sized for the widest build, units fill the low bits
	localparam int RES_W = 64;
	localparam int RD0_W = 12;

	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR  = 4'd3,
		OP_XOR = 4'd4,
		OP_SLL = 4'd5,
		OP_SRL = 4'd6,
		OP_SLT = 4'd7,
		OP_LI  = 4'd8,
		OP_MUL = 4'd9
	} op_t;

	// APB register offsets
	localparam logic [7:0] ADDR_IMM = 8'h00;
	localparam logic [7:0] ADDR_CMD = 8'h04;
	localparam logic [7:0] ADDR_STATUS = 8'h08;
	localparam logic [7:0] ADDR_RSEL = 8'h0C;
	localparam logic [7:0] ADDR_RDATA_LO = 8'h10;
	localparam logic [7:0] ADDR_RDATA_HI = 8'h14;

	// CMD word layout
	localparam int CMD_OP_LSB = 0;
	localparam int CMD_RD_LSB = 4;
	localparam int CMD_RS1_LSB = 9;
	localparam int CMD_RS2_LSB = 14;

	typedef struct packed {
		logic vaild;
		logic [RD0_W-1:0] rd0;
		logic [RES_W-1:0] res;
	} result_t;

endpackage

//--- verilog/issue_if.sv
// One issued operation, from the APB issue FSM to the execution units.
// valid is a single-cycle strobe; each unit picks the ops it implements.
interface issue_if #(
	parameter int XLEN = 64,
	parameter int PW = 7
);

	logic valid;
	wb_pkg::op_t op;
	logic [PW-1:0] rd0;
	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] imm;

	modport source (output valid, op, rd0, src1, src2, imm);

	modport sink (input valid, op, rd0, src1, src2, imm);

endinterface

//--- verilog/iter_counter.sv
// Iteration counter for the multiplier. start loads XLEN-1, then the count
// steps down once per cycle and rests at zero; last is high at zero.
module iter_counter #(
	parameter int XLEN = 64
) (
	input  logic pclk,
	input  logic rst_n,
	input  logic start,
	output logic [$clog2(XLEN)-1:0] count,
	output logic last
);
	localparam int CW = $clog2(XLEN);

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (start) begin
			count <= CW'(XLEN - 1);
		end else if (count != '0) begin
			count <= count - CW'(1);
		end
	end

	assign last = (count == '0);

endmodule

//--- verilog/alu_unit.sv
// Single-cycle ALU. Takes every issued op except OP_MUL and registers the
// result record, which is valid for one cycle after the issue strobe.
module alu_unit #(
	parameter int XLEN = 64,
	parameter int RP = 4
) (
	input  logic pclk,
	input  logic rst_n,
	issue_if.sink issue,
	output wb_pkg::result_t result
);
	localparam int PW = 5 + $clog2(RP);
	localparam int SW = $clog2(XLEN);

	logic accept;
	logic [XLEN-1:0] alu_out;

	assign accept = issue.valid && (issue.op != wb_pkg::OP_MUL);

	always_comb begin
		case (issue.op)
			wb_pkg::OP_ADD: alu_out = issue.src1 + issue.src2;
			wb_pkg::OP_SUB: alu_out = issue.src1 - issue.src2;
			wb_pkg::OP_AND: alu_out = issue.src1 & issue.src2;
			wb_pkg::OP_OR:  alu_out = issue.src1 | issue.src2;
			wb_pkg::OP_XOR: alu_out = issue.src1 ^ issue.src2;
			// shift amount from the low bits of src2 only
			wb_pkg::OP_SLL: alu_out = issue.src1 << issue.src2[SW-1:0];
			wb_pkg::OP_SRL: alu_out = issue.src1 >> issue.src2[SW-1:0];
			wb_pkg::OP_SLT: alu_out = XLEN'($signed(issue.src1) < $signed(issue.src2));
			wb_pkg::OP_LI:  alu_out = issue.imm;
			default: alu_out = '0;
		endcase
	end

	// upper record bits stay at their reset value
	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
		end else begin
			result.vaild <= accept;
			if (accept) begin
				result.rd0[PW-1:0] <= issue.rd0;
				result.res[XLEN-1:0] <= alu_out;
			end
		end
	end

endmodule

//--- verilog/mul_unit.sv
// Iterative shift-and-add multiplier, one multiplier bit per cycle.
// The product's low XLEN bits appear with vaild on the last iteration,
// so the copy is written XLEN+1 cycles after issue.
module mul_unit #(
	parameter int XLEN = 64,
	parameter int RP = 4
) (
	input  logic pclk,
	input  logic rst_n,
	issue_if.sink issue,
	output logic busy,
	output wb_pkg::result_t result
);
	localparam int CW = $clog2(XLEN);
	localparam int PW = 5 + $clog2(RP);

	logic start;
	logic run;
	logic last;
	logic [CW-1:0] count;
	logic [CW-1:0] step;
	logic [XLEN-1:0] mcand;
	logic [XLEN-1:0] mplier;
	logic [XLEN-1:0] acc;
	logic [XLEN-1:0] partial;
	logic [PW-1:0] rd0_q;

	assign start = issue.valid && (issue.op == wb_pkg::OP_MUL);
	assign busy = run || start;

	iter_counter #(.XLEN(XLEN)) u_iter (
		.pclk  (pclk),
		.rst_n (rst_n),
		.start (start),
		.count (count),
		.last  (last)
	);

	// counter runs down, so the bit index runs up from 0
	assign step = CW'(XLEN - 1) - count;
	assign partial = mplier[step] ? mcand : '0;

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n)
			run <= 1'b0;
		else if (start)
			run <= 1'b1;
		else if (last)
			run <= 1'b0;
	end

	always_ff @(posedge pclk) begin
		if (start) begin
			mcand <= issue.src1;
			mplier <= issue.src2;
			acc <= '0;
			rd0_q <= issue.rd0;
		end else if (run) begin
			acc <= acc + partial;
			mcand <= mcand << 1;
		end
	end

	// final partial product folded in combinationally
	always_comb begin
		result = '0;
		result.vaild = run && last;
		result.rd0[PW-1:0] = rd0_q;
		result.res[XLEN-1:0] = acc + partial;
	end

endmodule

//--- verilog/write_back.sv
// Writeback merge. Turns the unit result records into the next state of
// every physical register copy and a one-hot-per-result written set.
// Copies of x0 are held at zero whatever is written to them.
module write_back #(
	parameter int XLEN = 64,
	parameter int RP = 4
) (
	input  wb_pkg::result_t alu_res,
	input  wb_pkg::result_t mul_res,
	input  logic [XLEN*RP*wb_pkg::NREG-1:0] regs_qout,
	output logic [XLEN*RP*wb_pkg::NREG-1:0] regs_dnxt,
	output logic [RP*wb_pkg::NREG-1:0] written_set
);
	localparam int PW = 5 + $clog2(RP);
	localparam int NPHY = RP * wb_pkg::NREG;

	logic [PW-1:0] alu_rd0;
	logic [PW-1:0] mul_rd0;
	logic [XLEN-1:0] alu_val;
	logic [XLEN-1:0] mul_val;

	assign alu_rd0 = alu_res.rd0[PW-1:0];
	assign mul_rd0 = mul_res.rd0[PW-1:0];
	assign alu_val = alu_res.res[XLEN-1:0];
	assign mul_val = mul_res.res[XLEN-1:0];

	assign regs_dnxt[0 +: XLEN*RP] = '0;

	for (genvar sel = RP; sel < NPHY; sel++) begin : g_copy
		logic alu_hit;
		logic mul_hit;

		assign alu_hit = alu_res.vaild && (alu_rd0 == PW'(sel));
		assign mul_hit = mul_res.vaild && (mul_rd0 == PW'(sel));

		// units never target the same copy in one cycle
		assign regs_dnxt[XLEN*sel +: XLEN] =
			({XLEN{alu_hit}} & alu_val)
			| ({XLEN{mul_hit}} & mul_val)
			| ({XLEN{~(alu_hit | mul_hit)}} & regs_qout[XLEN*sel +: XLEN]);
	end

	always_comb begin
		written_set = '0;
		if (alu_res.vaild)
			written_set[alu_rd0] = 1'b1;
		if (mul_res.vaild)
			written_set[mul_rd0] = 1'b1;
	end

endmodule

//--- verilog/phy_regfile.sv
// Physical register file: RP copies of each architectural register, one
// rotating copy pointer per register and a written bit per copy.
// An allocation moves the pointer on and marks the new copy as pending.
module phy_regfile #(
	parameter int XLEN = 64,
	parameter int RP = 4
) (
	input  logic pclk,
	input  logic rst_n,
	input  logic [XLEN*RP*wb_pkg::NREG-1:0] regs_dnxt,
	input  logic [RP*wb_pkg::NREG-1:0] written_set,
	input  logic alloc_valid,
	input  logic [4:0] alloc_reg,
	output logic [XLEN*RP*wb_pkg::NREG-1:0] regs_qout,
	output logic [$clog2(RP)*wb_pkg::NREG-1:0] cur_copy,
	output logic [RP*wb_pkg::NREG-1:0] written_log
);
	localparam int RB = $clog2(RP);
	localparam int PW = 5 + RB;

	logic [RB-1:0] next_copy;
	logic [PW-1:0] alloc_idx;
	logic [RP*wb_pkg::NREG-1:0] log_nxt;

	assign next_copy = cur_copy[alloc_reg*RB +: RB] + RB'(1);
	assign alloc_idx = {alloc_reg, next_copy};

	// a fresh allocation wins over a late set of the same copy
	always_comb begin
		log_nxt = written_log | written_set;
		if (alloc_valid)
			log_nxt[alloc_idx] = 1'b0;
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			regs_qout <= '0;
			cur_copy <= '0;
			written_log <= '1;
		end else begin
			regs_qout <= regs_dnxt;
			written_log <= log_nxt;
			if (alloc_valid)
				cur_copy[alloc_reg*RB +: RB] <= next_copy;
		end
	end

endmodule

//--- verilog/apb_issue_fsm.sv
// APB slave of the writeback core. Keeps the immediate and read-select
// registers, renames destinations and issues one operation per CMD write.
// CMD writes and register reads hold pready low until their hazards clear.
module apb_issue_fsm #(
	parameter int XLEN = 64,
	parameter int RP = 4
) (
	input  logic pclk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	issue_if.source issue,
	input  logic [XLEN*RP*wb_pkg::NREG-1:0] regs_qout,
	input  logic [$clog2(RP)*wb_pkg::NREG-1:0] cur_copy,
	input  logic [RP*wb_pkg::NREG-1:0] written_log,
	input  logic mul_busy,
	output logic alloc_valid,
	output logic [4:0] alloc_reg
);
	localparam int RB = $clog2(RP);
	localparam int PW = 5 + RB;

	typedef enum logic [1:0] {IDLE, ACCESS, WAIT} state_t;

	state_t state;
	state_t state_nxt;
	logic [XLEN-1:0] imm_q;
	logic [4:0] rsel_q;
	wb_pkg::op_t cmd_op;
	logic [4:0] cmd_rd;
	logic [4:0] cmd_rs1;
	logic [4:0] cmd_rs2;
	logic [RB-1:0] rd_new_copy;
	logic [PW-1:0] src1_idx;
	logic [PW-1:0] src2_idx;
	logic [PW-1:0] rd_new_idx;
	logic [PW-1:0] rsel_idx;
	logic [63:0] rsel_val;
	logic [31:0] rdata;
	logic can_issue;
	logic mapped;
	logic hold;
	logic do_write;
	logic issue_now;

	// CMD fields come straight off the write data
	assign cmd_op = wb_pkg::op_t'(pwdata[wb_pkg::CMD_OP_LSB +: 4]);
	assign cmd_rd = pwdata[wb_pkg::CMD_RD_LSB +: 5];
	assign cmd_rs1 = pwdata[wb_pkg::CMD_RS1_LSB +: 5];
	assign cmd_rs2 = pwdata[wb_pkg::CMD_RS2_LSB +: 5];

	// current copies of the sources, next copy of the destination
	assign src1_idx = {cmd_rs1, cur_copy[cmd_rs1*RB +: RB]};
	assign src2_idx = {cmd_rs2, cur_copy[cmd_rs2*RB +: RB]};
	assign rd_new_copy = cur_copy[cmd_rd*RB +: RB] + RB'(1);
	assign rd_new_idx = {cmd_rd, rd_new_copy};
	assign rsel_idx = {rsel_q, cur_copy[rsel_q*RB +: RB]};

	assign can_issue = written_log[src1_idx] && written_log[src2_idx]
		&& (cmd_rd == 5'd0 || written_log[rd_new_idx])
		&& (cmd_op != wb_pkg::OP_MUL || !mul_busy);

	always_comb begin
		rsel_val = '0;
		rsel_val[XLEN-1:0] = regs_qout[rsel_idx*XLEN +: XLEN];
	end

	// register map decode
	always_comb begin
		mapped = 1'b1;
		hold = 1'b0;
		rdata = '0;
		case (paddr)
			wb_pkg::ADDR_IMM: rdata = imm_q[31:0];
			wb_pkg::ADDR_CMD: hold = pwrite && !can_issue;
			wb_pkg::ADDR_STATUS: rdata = {30'd0, ~&written_log, mul_busy};
			wb_pkg::ADDR_RSEL: rdata = {27'd0, rsel_q};
			wb_pkg::ADDR_RDATA_LO: begin
				hold = !pwrite && !written_log[rsel_idx];
				rdata = rsel_val[31:0];
			end
			wb_pkg::ADDR_RDATA_HI: begin
				hold = !pwrite && !written_log[rsel_idx];
				rdata = rsel_val[63:32];
			end
			default: mapped = 1'b0;
		endcase
	end

	assign pready = (state != IDLE) && psel && penable && !hold;
	assign pslverr = pready && !mapped;
	assign prdata = rdata;
	assign do_write = pready && pwrite && mapped;
	assign issue_now = do_write && (paddr == wb_pkg::ADDR_CMD);

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (psel && !penable)
					state_nxt = ACCESS;
			end
			default: begin
				if (pready || !psel)
					state_nxt = IDLE;
				else if (penable)
					state_nxt = WAIT;
			end
		endcase
	end

	always_ff @(posedge pclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			imm_q <= '0;
			rsel_q <= '0;
			issue.valid <= 1'b0;
			alloc_valid <= 1'b0;
		end else begin
			state <= state_nxt;
			issue.valid <= issue_now;
			// x0 never gets a new copy
			alloc_valid <= issue_now && (cmd_rd != 5'd0);
			if (do_write && paddr == wb_pkg::ADDR_IMM)
				imm_q <= XLEN'($signed(pwdata));
			if (do_write && paddr == wb_pkg::ADDR_RSEL)
				rsel_q <= pwdata[4:0];
		end
	end

	// operands are captured from the current copies at the issuing edge
	always_ff @(posedge pclk) begin
		if (issue_now) begin
			issue.op <= cmd_op;
			issue.rd0 <= (cmd_rd == 5'd0) ? '0 : rd_new_idx;
			issue.src1 <= regs_qout[src1_idx*XLEN +: XLEN];
			issue.src2 <= regs_qout[src2_idx*XLEN +: XLEN];
			issue.imm <= imm_q;
			alloc_reg <= cmd_rd;
		end
	end

endmodule

//--- verilog/wb_top.sv
// Top level of the writeback core. An APB host issues ALU and multiplier
// operations and reads back committed registers through plain APB ports.
// XLEN and RP set here are passed to every block below.
module wb_top #(
	parameter int XLEN = wb_pkg::XLEN_DEF,
	parameter int RP = wb_pkg::RP_DEF
) (
	input  logic pclk,
	input  logic rst_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [7:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	localparam int RB = $clog2(RP);
	localparam int PW = 5 + RB;
	localparam int NREG = wb_pkg::NREG;

	wb_pkg::result_t alu_res;
	wb_pkg::result_t mul_res;
	logic [XLEN*RP*NREG-1:0] regs_qout;
	logic [XLEN*RP*NREG-1:0] regs_dnxt;
	logic [RP*NREG-1:0] written_set;
	logic [RP*NREG-1:0] written_log;
	logic [RB*NREG-1:0] cur_copy;
	logic mul_busy;
	logic alloc_valid;
	logic [4:0] alloc_reg;

	issue_if #(.XLEN(XLEN), .PW(PW)) issue_bus ();

	apb_issue_fsm #(.XLEN(XLEN), .RP(RP)) u_fsm (
		.pclk        (pclk),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.issue       (issue_bus.source),
		.regs_qout   (regs_qout),
		.cur_copy    (cur_copy),
		.written_log (written_log),
		.mul_busy    (mul_busy),
		.alloc_valid (alloc_valid),
		.alloc_reg   (alloc_reg)
	);

	alu_unit #(.XLEN(XLEN), .RP(RP)) u_alu (
		.pclk   (pclk),
		.rst_n  (rst_n),
		.issue  (issue_bus.sink),
		.result (alu_res)
	);

	mul_unit #(.XLEN(XLEN), .RP(RP)) u_mul (
		.pclk   (pclk),
		.rst_n  (rst_n),
		.issue  (issue_bus.sink),
		.busy   (mul_busy),
		.result (mul_res)
	);

	write_back #(.XLEN(XLEN), .RP(RP)) u_wb (
		.alu_res     (alu_res),
		.mul_res     (mul_res),
		.regs_qout   (regs_qout),
		.regs_dnxt   (regs_dnxt),
		.written_set (written_set)
	);

	phy_regfile #(.XLEN(XLEN), .RP(RP)) u_regfile (
		.pclk        (pclk),
		.rst_n       (rst_n),
		.regs_dnxt   (regs_dnxt),
		.written_set (written_set),
		.alloc_valid (alloc_valid),
		.alloc_reg   (alloc_reg),
		.regs_qout   (regs_qout),
		.cur_copy    (cur_copy),
		.written_log (written_log)
	);

endmodule

//--- tests/tb_wb_top.sv
// Directed testbench for the writeback core. Drives APB transfers on falling
// clock edges, mirrors the 32 architectural registers in a model and checks
// every readback against it. Stops at the first mismatch.
module tb_wb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int XLEN = wb_pkg::XLEN_DEF;
	localparam int RP = wb_pkg::RP_DEF;
	localparam int NREG = wb_pkg::NREG;
	localparam int RAND_OPS = 40;
	// rough count of APB transfers over all tests
	localparam int NUM_OPS = (3 * NREG + 4) + 60 + 20 + 80 + 40 + (2 * RAND_OPS + 3 * NREG);

	logic pclk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	logic [XLEN-1:0] model [NREG];
	logic [XLEN-1:0] imm_model;
	integer seed;

	wb_top #(.XLEN(XLEN), .RP(RP)) UUT (
		.pclk    (pclk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	initial begin
		pclk = 1'b0;
		forever #4 pclk = ~pclk;
	end

	initial begin
		repeat (NUM_OPS * (XLEN + 20)) @(posedge pclk);
		$display("Timeout: the DUT stopped answering before the tests finished");
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	task automatic check_equal(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
				$time, msg, actual, expected);
			$display("Test failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// setup on one falling edge, access on the next, then wait for pready
	task automatic apb_transfer(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge pclk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge pclk);
		penable = 1'b1;
		#1;
		while (!pready) begin
			@(negedge pclk);
			#1;
		end
		rdata = prdata;
		err = pslverr;
		@(posedge pclk);
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused_rdata;
		logic err;
		apb_transfer(1'b1, addr, data, unused_rdata, err);
		if (err) begin
			$display("APB write to offset %h got an error response at %0t ns", addr, $time);
			$display("Test failed");
			$fatal(1, "unexpected pslverr");
		end
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		logic err;
		apb_transfer(1'b0, addr, 32'd0, data, err);
		if (err) begin
			$display("APB read of offset %h got an error response at %0t ns", addr, $time);
			$display("Test failed");
			$fatal(1, "unexpected pslverr");
		end
	endtask

	// reference behavior of each op
	function automatic logic [XLEN-1:0] expected_result(input logic [3:0] op,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm);
		logic [$clog2(XLEN)-1:0] sh;
		sh = b[$clog2(XLEN)-1:0];
		case (op)
			wb_pkg::OP_ADD: return a + b;
			wb_pkg::OP_SUB: return a - b;
			wb_pkg::OP_AND: return a & b;
			wb_pkg::OP_OR: return a | b;
			wb_pkg::OP_XOR: return a ^ b;
			wb_pkg::OP_SLL: return a << sh;
			wb_pkg::OP_SRL: return a >> sh;
			wb_pkg::OP_SLT: return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			wb_pkg::OP_LI: return imm;
			wb_pkg::OP_MUL: return a * b;
			default: return '0;
		endcase
	endfunction

	task automatic set_imm(input logic [31:0] value);
		apb_write(wb_pkg::ADDR_IMM, value);
		imm_model = {{(XLEN-32){value[31]}}, value};
	endtask

	task automatic issue_op(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2);
		logic [31:0] cmd;
		cmd = 32'd0;
		cmd[wb_pkg::CMD_OP_LSB +: 4] = op;
		cmd[wb_pkg::CMD_RD_LSB +: 5] = rd;
		cmd[wb_pkg::CMD_RS1_LSB +: 5] = rs1;
		cmd[wb_pkg::CMD_RS2_LSB +: 5] = rs2;
		apb_write(wb_pkg::ADDR_CMD, cmd);
		// x0 discards its result
		if (rd != 5'd0)
			model[rd] = expected_result(op, model[rs1], model[rs2], imm_model);
	endtask

	task automatic load_value(input logic [4:0] rd, input logic [31:0] value);
		set_imm(value);
		issue_op(wb_pkg::OP_LI, rd, 5'd0, 5'd0);
	endtask

	task automatic read_reg(input logic [4:0] r, output logic [XLEN-1:0] value);
		logic [31:0] lo;
		logic [31:0] hi;
		apb_write(wb_pkg::ADDR_RSEL, {27'd0, r});
		apb_read(wb_pkg::ADDR_RDATA_LO, lo);
		apb_read(wb_pkg::ADDR_RDATA_HI, hi);
		value = {hi, lo};
	endtask

	task automatic check_reg(input logic [4:0] r);
		logic [XLEN-1:0] value;
		read_reg(r, value);
		check_equal(value, model[r], $sformatf("readback of x%0d", r));
	endtask

	task automatic check_all_regs();
		for (int r = 0; r < NREG; r++)
			check_reg(5'(r));
	endtask

	task automatic reset_state_checks();
		logic [31:0] status;
		logic [31:0] rdata;
		logic err;
		check_all_regs();
		apb_read(wb_pkg::ADDR_STATUS, status);
		check_equal(XLEN'(status), '0, "STATUS after reset");
		apb_transfer(1'b0, 8'h20, 32'd0, rdata, err);
		check_equal(XLEN'(err), XLEN'(1), "pslverr on an unmapped read");
	endtask

	task automatic alu_op_sweep();
		// x1 is negative once sign-extended
		load_value(5'd1, 32'h8000_1234);
		load_value(5'd2, 32'h0000_0025);
		issue_op(wb_pkg::OP_ADD, 5'd3, 5'd1, 5'd2);
		issue_op(wb_pkg::OP_SUB, 5'd4, 5'd1, 5'd2);
		issue_op(wb_pkg::OP_AND, 5'd5, 5'd1, 5'd2);
		issue_op(wb_pkg::OP_OR, 5'd6, 5'd1, 5'd2);
		issue_op(wb_pkg::OP_XOR, 5'd7, 5'd1, 5'd2);
		issue_op(wb_pkg::OP_SLL, 5'd8, 5'd1, 5'd2);
		issue_op(wb_pkg::OP_SRL, 5'd9, 5'd1, 5'd2);
		issue_op(wb_pkg::OP_SLT, 5'd10, 5'd1, 5'd2);
		issue_op(wb_pkg::OP_SLT, 5'd11, 5'd2, 5'd1);
		for (int r = 1; r <= 11; r++)
			check_reg(5'(r));
	endtask

	task automatic multiplier_product();
		logic [31:0] a;
		logic [31:0] b;
		a = $random(seed);
		b = $random(seed);
		load_value(5'd12, a);
		load_value(5'd13, b);
		issue_op(wb_pkg::OP_MUL, 5'd14, 5'd12, 5'd13);
		check_reg(5'd14);
		// full-width operands on the second pass
		issue_op(wb_pkg::OP_MUL, 5'd15, 5'd14, 5'd1);
		check_reg(5'd15);
	endtask

	task automatic mul_alu_overlap();
		logic [31:0] status;
		issue_op(wb_pkg::OP_MUL, 5'd16, 5'd1, 5'd13);
		issue_op(wb_pkg::OP_ADD, 5'd17, 5'd2, 5'd3);
		issue_op(wb_pkg::OP_XOR, 5'd18, 5'd17, 5'd1);
		issue_op(wb_pkg::OP_SUB, 5'd19, 5'd12, 5'd13);
		issue_op(wb_pkg::OP_SLL, 5'd20, 5'd13, 5'd2);
		apb_read(wb_pkg::ADDR_STATUS, status);
		check_equal(XLEN'(status[0]), XLEN'(1), "multiplier busy during ALU ops");
		check_equal(XLEN'(status[1]), XLEN'(1), "product copy pending during ALU ops");
		// two interleaved accumulators give an ALU write every other cycle
		// for longer than the multiply, so one lands with the product
		for (int i = 0; i < XLEN / 4; i++) begin
			issue_op(wb_pkg::OP_ADD, 5'd21, 5'd21, 5'd2);
			issue_op(wb_pkg::OP_ADD, 5'd25, 5'd25, 5'd13);
		end
		for (int r = 16; r <= 21; r++)
			check_reg(5'(r));
		check_reg(5'd25);
	endtask

	task automatic rename_and_x0();
		for (int i = 0; i < 2 * RP + 1; i++) begin
			issue_op(wb_pkg::OP_ADD, 5'd22, 5'd22, 5'd1);
			issue_op(wb_pkg::OP_XOR, 5'd23, 5'd22, 5'd23);
		end
		check_reg(5'd22);
		check_reg(5'd23);
		load_value(5'd0, 32'h1234_5678);
		issue_op(wb_pkg::OP_ADD, 5'd0, 5'd1, 5'd2);
		check_reg(5'd0);
		issue_op(wb_pkg::OP_OR, 5'd24, 5'd0, 5'd2);
		check_reg(5'd24);
	endtask

	task automatic random_sequence();
		logic [31:0] r;
		logic [31:0] value;
		logic [3:0] op;
		for (int i = 0; i < RAND_OPS; i++) begin
			r = $random(seed);
			op = r[31:28] % 4'd10;
			if (op == wb_pkg::OP_LI) begin
				value = $random(seed);
				set_imm(value);
			end
			issue_op(op, r[4:0], r[9:5], r[14:10]);
		end
		check_all_regs();
	endtask

	initial begin
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'd0;
		pwdata = 32'd0;
		seed = 32'h326e_922c;
		imm_model = '0;
		for (int i = 0; i < NREG; i++)
			model[i] = '0;
		repeat (3) @(posedge pclk);
		@(negedge pclk);
		rst_n = 1'b1;

		reset_state_checks();
		alu_op_sweep();
		multiplier_product();
		mul_alu_overlap();
		rename_and_x0();
		random_sequence();

		@(negedge pclk);
		psel = 1'b0;
		penable = 1'b0;
		$display("Test passed");
		$finish;
	end

endmodule

//--- src.f
verilog/wb_pkg.sv
verilog/issue_if.sv
verilog/iter_counter.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/write_back.sv
verilog/phy_regfile.sv
verilog/apb_issue_fsm.sv
verilog/wb_top.sv
tests/tb_wb_top.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps
LINT      = --lint-only -Wall --timing --timescale 1ns/1ps
TOP       = tb_wb_top
LINT_TOP  = wb_top
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(TOOL) $(LINT) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
